// ==== source/sa_pkg.sv ====
package sa_pkg;

    // Array shape and arithmetic widths
    localparam int DATA_WIDTH = 8;
    localparam int ACC_WIDTH  = 2 * DATA_WIDTH;
    localparam int ARRAY_K    = 3;    // Weight rows, also the A row length
    localparam int ARRAY_N    = 4;    // Weight columns, also the result row length

    // Cycles from skewed element 0 to the aligned result row
    localparam int VALID_DELAY = ARRAY_K + ARRAY_N - 1;

    typedef logic [DATA_WIDTH-1:0] data_t;
    typedef logic [ACC_WIDTH-1:0]  acc_t;

    // Row index first, column index second
    typedef data_t [0:ARRAY_K-1][0:ARRAY_N-1] weight_mat_t;

    typedef struct packed {
        logic                  valid;
        data_t [0:ARRAY_K-1]   elems;
    } a_row_s;

    // Element k lags element 0 by k cycles, valid travels with element 0
    typedef struct packed {
        logic                  valid;
        data_t [0:ARRAY_K-1]   elems;
    } skew_row_s;

    typedef struct packed {
        acc_t [0:ARRAY_N-1]    sums;
    } sum_row_s;

    typedef struct packed {
        logic                  valid;
        acc_t [0:ARRAY_N-1]    sums;
    } result_row_s;

endpackage

// ==== source/sa_cell.sv ====
module sa_cell
    import sa_pkg::*;
(
    input  logic  clk,
    input  logic  arst_n,
    input  logic  weight_load,
    input  data_t weight_in,
    input  data_t data_in,
    input  acc_t  sum_in,
    output data_t data_out,
    output acc_t  sum_out
);

    data_t weight_q;    // Stationary weight
    acc_t  product;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            weight_q <= '0;
        end
        else if (weight_load)
        begin
            weight_q <= weight_in;
        end
    end

    // Full-width product, the sum wraps at ACC_WIDTH
    assign product = acc_t'(data_in) * acc_t'(weight_q);

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            data_out <= '0;
            sum_out  <= '0;
        end
        else
        begin
            data_out <= data_in;              // Operand moves one column right
            sum_out  <= sum_in + product;     // Partial sum moves one row down
        end
    end

endmodule

// ==== source/sa_array.sv ====
module sa_array
    import sa_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n,
    input  logic        weight_load,
    input  weight_mat_t weights,
    input  skew_row_s   skew_row,
    output sum_row_s    column_sums
);

    // Registered outputs of every cell
    data_t [0:ARRAY_K-1][0:ARRAY_N-1] data_w;
    acc_t  [0:ARRAY_K-1][0:ARRAY_N-1] sum_w;

    // k walks the rows, j walks the columns
    for (genvar k = 0; k < ARRAY_K; k++)
    begin : g_row
        for (genvar j = 0; j < ARRAY_N; j++)
        begin : g_col
            data_t data_left;
            acc_t  sum_above;

            // Left edge takes the skewed operand, the rest take the neighbour's
            if (j == 0)
            begin : g_edge_data
                assign data_left = skew_row.elems[k];
            end
            else
            begin : g_inner_data
                assign data_left = data_w[k][j-1];
            end

            // Top row starts every column from zero
            if (k == 0)
            begin : g_edge_sum
                assign sum_above = '0;
            end
            else
            begin : g_inner_sum
                assign sum_above = sum_w[k-1][j];
            end

            sa_cell i_sa_cell (
                .clk         (clk),
                .arst_n      (arst_n),
                .weight_load (weight_load),
                .weight_in   (weights[k][j]),
                .data_in     (data_left),
                .sum_in      (sum_above),
                .data_out    (data_w[k][j]),
                .sum_out     (sum_w[k][j])
            );
        end
    end

    // Bottom row carries the finished column sums
    for (genvar j = 0; j < ARRAY_N; j++)
    begin : g_out
        assign column_sums.sums[j] = sum_w[ARRAY_K-1][j];
    end

endmodule

// ==== source/sa_skew_feeder.sv ====
module sa_skew_feeder
    import sa_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,
    input  a_row_s    a_row,
    output skew_row_s skew_row
);

    a_row_s row_q;    // Input stage

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            row_q <= '0;
        end
        else
        begin
            row_q.valid <= a_row.valid;
            // Bubbles enter the array as zeros
            row_q.elems <= a_row.valid ? a_row.elems : '0;
        end
    end

    assign skew_row.valid = row_q.valid;

    // Element k waits k extra cycles
    for (genvar k = 0; k < ARRAY_K; k++)
    begin : g_elem
        if (k == 0)
        begin : g_direct
            assign skew_row.elems[k] = row_q.elems[k];
        end
        else
        begin : g_delay
            data_t [1:k] chain;

            always_ff @(posedge clk or negedge arst_n)
            begin
                if (!arst_n)
                begin
                    chain <= '0;
                end
                else
                begin
                    chain[1] <= row_q.elems[k];
                    for (int s = 2; s <= k; s++)
                    begin
                        chain[s] <= chain[s-1];
                    end
                end
            end

            assign skew_row.elems[k] = chain[k];
        end
    end

endmodule

// ==== source/sa_result_collector.sv ====
module sa_result_collector
    import sa_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n,
    input  logic        in_valid,
    input  sum_row_s    column_sums,
    output result_row_s result
);

    logic [1:VALID_DELAY] valid_sr;

    // Valid follows the row through skew, array and de-skew
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            valid_sr <= '0;
        end
        else
        begin
            valid_sr <= {in_valid, valid_sr[1:VALID_DELAY-1]};
        end
    end

    assign result.valid = valid_sr[VALID_DELAY];

    // Column j leaves the array j cycles after column 0,
    // so it is held back by ARRAY_N-1-j cycles
    for (genvar j = 0; j < ARRAY_N; j++)
    begin : g_col
        if (j == ARRAY_N - 1)
        begin : g_direct
            assign result.sums[j] = column_sums.sums[j];    // Last column arrives last
        end
        else
        begin : g_delay
            acc_t [1:ARRAY_N-1-j] chain;

            always_ff @(posedge clk or negedge arst_n)
            begin
                if (!arst_n)
                begin
                    chain <= '0;
                end
                else
                begin
                    chain[1] <= column_sums.sums[j];
                    for (int s = 2; s <= ARRAY_N - 1 - j; s++)
                    begin
                        chain[s] <= chain[s-1];
                    end
                end
            end

            assign result.sums[j] = chain[ARRAY_N-1-j];
        end
    end

endmodule

// ==== source/sa_matmul_top.sv ====
module sa_matmul_top
    import sa_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n,
    input  logic        weight_load,
    input  weight_mat_t weights,
    input  a_row_s      a_row,
    output result_row_s result
);

    skew_row_s skew_row;
    sum_row_s  column_sums;

    // Staggers each row diagonally
    sa_skew_feeder i_sa_skew_feeder (
        .clk      (clk),
        .arst_n   (arst_n),
        .a_row    (a_row),
        .skew_row (skew_row)
    );

    // Weight-stationary grid
    sa_array i_sa_array (
        .clk         (clk),
        .arst_n      (arst_n),
        .weight_load (weight_load),
        .weights     (weights),
        .skew_row    (skew_row),
        .column_sums (column_sums)
    );

    // Realigns the column sums into one row
    sa_result_collector i_sa_result_collector (
        .clk         (clk),
        .arst_n      (arst_n),
        .in_valid    (skew_row.valid),
        .column_sums (column_sums),
        .result      (result)
    );

endmodule

// ==== sim/tb_sa_matmul.sv ====
module tb_sa_matmul
    import sa_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int LATENCY = ARRAY_K + ARRAY_N;    // Input edge to result row
    localparam int TIMEOUT = 50;

    typedef struct packed {
        logic [31:0] due;     // Cycle count at which the row must show up
        sum_row_s    sums;
    } expect_s;

    logic        clk;
    logic        arst_n;
    logic        weight_load;
    weight_mat_t weights;
    a_row_s      a_row;
    result_row_s result;

    weight_mat_t cur_w;       // Weights seen by the reference model
    expect_s     exp_q[$];
    logic [31:0] cycle_cnt = '0;
    integer      seed = 80337;

    sa_matmul_top i_sa_matmul_top (
        .clk         (clk),
        .arst_n      (arst_n),
        .weight_load (weight_load),
        .weights     (weights),
        .a_row       (a_row),
        .result      (result)
    );

    always #50 clk = ~clk;

    always @(posedge clk)
    begin
        cycle_cnt <= cycle_cnt + 1;
    end

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("SOME TESTS FAILED");
        $fatal(1, "Simulation stopped on error");
    endtask

    task automatic check_equal(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
        if (actual !== expected)
        begin
            $display("mismatch at %0d ns: %s, got %0d, expected %0d",
                     $time, what, actual, expected);
            stop_with_failure("A checked value was wrong");
        end
    endtask

    // Row times W, each column sum wrapped to ACC_WIDTH bits
    function automatic sum_row_s ref_row(input data_t [0:ARRAY_K-1] elems,
                                         input weight_mat_t w);
        sum_row_s    r;
        logic [31:0] acc;
        for (int j = 0; j < ARRAY_N; j++)
        begin
            acc = 0;
            for (int k = 0; k < ARRAY_K; k++)
            begin
                acc = acc + 32'(elems[k]) * 32'(w[k][j]);
            end
            r.sums[j] = acc[ACC_WIDTH-1:0];
        end
        return r;
    endfunction

    function automatic a_row_s random_row();
        a_row_s row;
        row.valid = 1'b1;
        for (int k = 0; k < ARRAY_K; k++)
        begin
            row.elems[k] = data_t'($random(seed));
        end
        return row;
    endfunction

    function automatic weight_mat_t random_weights();
        weight_mat_t w;
        for (int k = 0; k < ARRAY_K; k++)
        begin
            for (int j = 0; j < ARRAY_N; j++)
            begin
                w[k][j] = data_t'($random(seed));
            end
        end
        return w;
    endfunction

    task automatic load_weights(input weight_mat_t w);
        weights     = w;
        weight_load = 1'b1;
        cur_w       = w;
        @(negedge clk);
        weight_load = 1'b0;
        @(negedge clk);
    endtask

    // Drives one valid row and books its expected result
    task automatic drive_row(input a_row_s row);
        expect_s e;
        a_row       = row;
        a_row.valid = 1'b1;
        e.due       = cycle_cnt + LATENCY;
        e.sums      = ref_row(row.elems, cur_w);
        exp_q.push_back(e);
        @(negedge clk);
    endtask

    task automatic drive_bubble();
        a_row_s row;
        row       = random_row();
        row.valid = 1'b0;     // Elements are noise and must not reach a result
        a_row     = row;
        @(negedge clk);
    endtask

    // Waits until every booked row has come back
    task automatic wait_result();
        int waited;
        waited = 0;
        while (exp_q.size() != 0)
        begin
            if (waited >= TIMEOUT)
            begin
                stop_with_failure("No result row arrived within the timeout");
            end
            else
            begin
                @(negedge clk);
                waited++;
            end
        end
    endtask

    // Result monitor, sampled away from the rising edge
    always @(negedge clk)
    begin : monitor
        expect_s e;
        if (result.valid)
        begin
            if (exp_q.size() == 0)
            begin
                stop_with_failure("A result row appeared with no row outstanding");
            end
            else
            begin
                e = exp_q.pop_front();
                check_equal(64'(cycle_cnt), 64'(e.due), "result cycle");
                for (int j = 0; j < ARRAY_N; j++)
                begin
                    check_equal(64'(result.sums[j]), 64'(e.sums.sums[j]),
                                $sformatf("sum %0d", j));
                end
            end
        end
        else if (exp_q.size() != 0 && exp_q[0].due == cycle_cnt)
        begin
            stop_with_failure("An expected result row did not appear on time");
        end
    end

    task automatic reset_state();
        for (int i = 0; i < 20; i++)
        begin
            check_equal(64'(result.valid), '0, "valid after reset");
            check_equal(result.sums, '0, "sums after reset");
            @(negedge clk);
        end
    endtask

    task automatic identity_weights();
        weight_mat_t w;
        a_row_s      row;
        logic [31:0] start;
        int          waited;
        for (int k = 0; k < ARRAY_K; k++)
        begin
            for (int j = 0; j < ARRAY_N; j++)
            begin
                w[k][j] = (k == j) ? 8'd1 : 8'd0;
            end
        end
        load_weights(w);
        row   = random_row();
        start = cycle_cnt;
        drive_row(row);
        a_row  = '0;
        waited = 0;
        while (!result.valid)
        begin
            if (waited >= TIMEOUT)
            begin
                stop_with_failure("No result row arrived for the identity test");
            end
            else
            begin
                @(negedge clk);
                waited++;
            end
        end
        check_equal(64'(cycle_cnt - start), 64'(LATENCY), "identity latency");
        for (int j = 0; j < ARRAY_N; j++)
        begin
            check_equal(64'(result.sums[j]), 64'((j < ARRAY_K) ? row.elems[j] : 8'd0),
                        $sformatf("identity sum %0d", j));
        end
        wait_result();
    endtask

    task automatic single_rows();
        load_weights(random_weights());
        repeat (5)
        begin
            drive_row(random_row());
            a_row = '0;
            wait_result();
        end
    endtask

    task automatic back_to_back_stream();
        repeat (20)
        begin
            drive_row(random_row());    // Valid stays high across rows
        end
        a_row = '0;
        wait_result();
    endtask

    task automatic gapped_stream_and_overflow();
        a_row_s row;
        row.valid = 1'b1;
        row.elems = '1;
        load_weights('1);               // Largest operands force a wrap
        for (int i = 0; i < 30; i++)
        begin
            if ($random(seed) & 1)
            begin
                drive_row(row);
            end
            else
            begin
                drive_bubble();
            end
        end
        a_row = '0;
        wait_result();
    endtask

    task automatic weight_reload();
        wait_result();
        load_weights(random_weights());
        repeat (8)
        begin
            drive_row(random_row());
        end
        a_row = '0;
        wait_result();
    endtask

    initial
    begin
        clk          = 1'b0;
        arst_n       = 1'b0;
        weight_load  = 1'b0;
        weights      = '0;
        a_row        = '0;
        cur_w        = '0;
        repeat (10) @(negedge clk);
        arst_n = 1'b1;

        reset_state();
        identity_weights();
        single_rows();
        back_to_back_stream();
        gapped_stream_and_overflow();
        weight_reload();

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// ==== sim.f ====
source/sa_pkg.sv
source/sa_cell.sv
source/sa_array.sv
source/sa_skew_feeder.sv
source/sa_result_collector.sv
source/sa_matmul_top.sv
sim/tb_sa_matmul.sv

// ==== Makefile ====
# Verilator flow for the systolic matrix-multiply testbench

VERILATOR ?= verilator
TOP       ?= tb_sa_matmul
RTL_TOP   ?= sa_matmul_top
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --timescale 1ns/100ps
PASS_MSG  ?= ALL TESTS PASSED

SOURCES := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	@out="$$($(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
